// File: src/tdc_settings.svh
// TDC core settings
`ifndef TDC_SETTINGS_SVH
`define TDC_SETTINGS_SVH

`define TDC_SAMPLE_W    16        // samples per CLK40 word
`define TDC_TOT_W       12        // measured value width
`define TDC_EVT_W       16        // event number width
`define TDC_DATA_ID     4'b0100   // top nibble of every word
`define TDC_FIFO_DEPTH  16        // words, power of two
`define TDC_AXI_ADDR_W  6

`define TDC_REG_RESET   6'h00     // any write pulses soft reset
`define TDC_REG_CONFIG  6'h04     // bit 0 enable, bit 1 arm enable
`define TDC_REG_LOST    6'h08
`define TDC_REG_EVENTS  6'h0C
`define TDC_REG_STATUS  6'h10
`define TDC_REG_DATA    6'h14     // read pops the FIFO

`endif

// File: src/tdc_pkg.sv
// TDC shared types
`include "tdc_settings.svh"

package tdc_pkg;

    typedef logic [`TDC_SAMPLE_W-1:0] sample_t;    // bit 15 oldest, bit 0 newest
    typedef logic [4:0]               ones_t;      // 0 to 16 ones
    typedef logic [`TDC_TOT_W-1:0]    tot_t;
    typedef logic [`TDC_TOT_W:0]      tot_acc_t;   // msb is the overflow bit
    typedef logic [`TDC_EVT_W-1:0]    evt_cnt_t;
    typedef logic [7:0]               lost_cnt_t;  // saturates at 255
    typedef logic [31:0]              tdc_word_t;  // id, event number, value

    // occupancy needs one bit more than the pointers
    typedef logic [$clog2(`TDC_FIFO_DEPTH):0] fifo_cnt_t;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        ARMED = 2'b01,
        COUNT = 2'b10
    } hit_state_t;

endpackage

// File: src/tdc_meas_if.sv
// Measurement handshake interface
`timescale 1ns/1ps

interface tdc_meas_if;

    logic          hit_any;     // registered word has a one
    logic          hit_gap;     // registered word has a zero
    logic          hit_short;   // ones but newest bit low
    logic          start;
    logic          finish;
    logic          short_done;  // finish caused by a short hit
    tdc_pkg::tot_t tot_val;     // valid with finish

    modport counter (output hit_any, hit_gap, hit_short, tot_val,
                     input  start, finish, short_done);

    modport fsm     (input  hit_any, hit_gap, hit_short,
                     output start, finish, short_done);

    modport packer  (input  finish, tot_val);

endinterface

// File: src/tdc_hit_fsm.sv
// Hit detection state machine
`timescale 1ns/1ps

module tdc_hit_fsm (
    input  logic   CLK40,
    input  logic   RST,
    input  logic   soft_rst,
    input  logic   enable,
    input  logic   arm_enable,
    input  logic   arm,          // synchronous, one cycle
    tdc_meas_if.fsm meas
);

    tdc_pkg::hit_state_t state;
    tdc_pkg::hit_state_t next_state;
    logic                long_hit;

    assign long_hit = meas.hit_any && !meas.hit_short; // pulse reaches newest sample

    always_ff @(posedge CLK40) begin
        if (RST || soft_rst) begin
            state <= tdc_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state      = state;
        meas.start      = 1'b0;
        meas.finish     = 1'b0;
        meas.short_done = 1'b0;
        unique case (state)
            tdc_pkg::IDLE: begin
                if (enable && !arm_enable) begin
                    if (long_hit) begin
                        meas.start = 1'b1;
                        next_state = tdc_pkg::COUNT;
                    end else if (meas.hit_short) begin
                        meas.finish     = 1'b1; // whole pulse inside one word
                        meas.short_done = 1'b1;
                    end
                end else if (enable && arm && arm_enable) begin
                    next_state = tdc_pkg::ARMED;
                end
            end
            tdc_pkg::ARMED: begin
                if (!enable) begin
                    next_state = tdc_pkg::IDLE;
                end else if (long_hit) begin
                    meas.start = 1'b1;
                    next_state = tdc_pkg::COUNT;
                end else if (meas.hit_short) begin
                    meas.finish     = 1'b1;
                    meas.short_done = 1'b1;
                    next_state      = tdc_pkg::IDLE; // one pulse per arm
                end
            end
            tdc_pkg::COUNT: begin
                if (meas.hit_gap || !enable) begin
                    meas.finish = 1'b1;
                    next_state  = tdc_pkg::IDLE;
                end
            end
            default: next_state = tdc_pkg::IDLE;
        endcase
    end

    a_start_finish_excl: assert property (@(posedge CLK40) disable iff (RST)
        !(meas.start && meas.finish));

endmodule

// File: src/tdc_tot_counter.sv
// Time over threshold counter
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_tot_counter (
    input  logic             CLK40,
    input  logic             RST,
    input  logic             soft_rst,
    input  tdc_pkg::sample_t sample,
    tdc_meas_if.counter      meas
);

    tdc_pkg::sample_t  sample_q;
    tdc_pkg::ones_t    ones;
    tdc_pkg::tot_acc_t acc;
    tdc_pkg::tot_acc_t acc_sum;
    logic              counting;   // mirrors the COUNT state
    logic              overflow;

    always_ff @(posedge CLK40) begin
        if (RST) begin
            sample_q <= '0;
        end else begin
            sample_q <= sample;
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < `TDC_SAMPLE_W; i++) begin
            ones = ones + tdc_pkg::ones_t'(sample_q[i]);
        end
    end

    assign meas.hit_any   = |sample_q;
    assign meas.hit_gap   = |(~sample_q);
    assign meas.hit_short = meas.hit_any && !sample_q[0];

    assign acc_sum  = acc + tdc_pkg::tot_acc_t'(ones);
    assign overflow = acc_sum[`TDC_TOT_W];

    always_ff @(posedge CLK40) begin
        if (RST || soft_rst) begin
            acc      <= '0;
            counting <= 1'b0;
        end else begin
            if (meas.start) begin
                acc      <= tdc_pkg::tot_acc_t'(ones);
                counting <= 1'b1;
            end else if (counting) begin
                if (overflow || acc == '0) begin
                    acc <= '0;            // stuck at zero until next start
                end else begin
                    acc <= acc_sum;
                end
            end
            if (meas.finish) begin
                counting <= 1'b0;
            end
        end
    end

    assign meas.tot_val = meas.short_done ? tdc_pkg::tot_t'(ones) :
                          (!overflow && acc != '0) ? acc_sum[`TDC_TOT_W-1:0] : '0;

    a_ones_range: assert property (@(posedge CLK40) disable iff (RST)
        ones <= `TDC_SAMPLE_W);

endmodule

// File: src/tdc_event_packer.sv
// Event word packer
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_event_packer (
    input  logic               CLK40,
    input  logic               RST,
    input  logic               soft_rst,
    tdc_meas_if.packer         meas,
    input  logic               fifo_full,
    output logic               fifo_wr,
    output tdc_pkg::tdc_word_t fifo_wdata,
    output tdc_pkg::evt_cnt_t  event_cnt,
    output tdc_pkg::lost_cnt_t lost_cnt
);

    logic lost_sat;

    assign lost_sat = (lost_cnt == '1);

    // word goes in on the edge that closes the finish cycle
    assign fifo_wr    = meas.finish && !fifo_full;
    assign fifo_wdata = {`TDC_DATA_ID, event_cnt, meas.tot_val};

    always_ff @(posedge CLK40) begin
        if (RST || soft_rst) begin
            event_cnt <= '0;
        end else if (meas.finish) begin
            event_cnt <= event_cnt + 1'b1; // counts dropped words too
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST || soft_rst) begin
            lost_cnt <= '0;
        end else if (meas.finish && fifo_full && !lost_sat) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

endmodule

// File: src/tdc_event_fifo.sv
// Event word FIFO
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_event_fifo (
    input  logic               CLK40,
    input  logic               RST,
    input  logic               soft_rst,
    input  logic               wr,
    input  logic               rd,
    input  tdc_pkg::tdc_word_t wdata,
    output tdc_pkg::tdc_word_t rdata,
    output logic               full,
    output logic               empty,
    output tdc_pkg::fifo_cnt_t count
);

    localparam int AW = $clog2(`TDC_FIFO_DEPTH);

    tdc_pkg::tdc_word_t mem [`TDC_FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = wr && !full;
    assign rd_en = rd && !empty;

    always_ff @(posedge CLK40) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST || soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rdata = mem[rd_ptr];  // head word always visible
    assign full  = (count == tdc_pkg::fifo_cnt_t'(`TDC_FIFO_DEPTH));
    assign empty = (count == '0);

    a_no_wr_full:  assert property (@(posedge CLK40) disable iff (RST) wr |-> !full);
    a_no_rd_empty: assert property (@(posedge CLK40) disable iff (RST) rd |-> !empty);

endmodule

// File: src/tdc_axil_regs.sv
// AXI4-Lite register block
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_axil_regs (
    input  logic                       CLK40,
    input  logic                       RST,
    input  logic [`TDC_AXI_ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`TDC_AXI_ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       enable,
    output logic                       arm_enable,
    output logic                       soft_rst,
    output logic                       fifo_pop,
    input  tdc_pkg::evt_cnt_t          event_cnt,
    input  tdc_pkg::lost_cnt_t         lost_cnt,
    input  tdc_pkg::tdc_word_t         fifo_rdata,
    input  logic                       fifo_empty,
    input  tdc_pkg::fifo_cnt_t         fifo_count
);

    logic        wr_hs;
    logic        rd_hs;
    logic [31:0] rd_mux;

    // address and data accepted together, one at a time
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign bresp   = 2'b00;

    always_ff @(posedge CLK40) begin
        if (RST) begin
            bvalid     <= 1'b0;
            soft_rst   <= 1'b0;
            enable     <= 1'b0;
            arm_enable <= 1'b0;
        end else begin
            soft_rst <= wr_hs && (awaddr == `TDC_REG_RESET);
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs && awaddr == `TDC_REG_CONFIG && wstrb[0]) begin
                enable     <= wdata[0];
                arm_enable <= wdata[1];
            end
        end
    end

    assign arready  = !rvalid;
    assign rd_hs    = arvalid && arready;
    assign rresp    = 2'b00;
    assign fifo_pop = rd_hs && (araddr == `TDC_REG_DATA) && !fifo_empty;

    always_comb begin
        case (araddr)
            `TDC_REG_CONFIG: rd_mux = {30'b0, arm_enable, enable};
            `TDC_REG_LOST:   rd_mux = 32'(lost_cnt);
            `TDC_REG_EVENTS: rd_mux = 32'(event_cnt);
            `TDC_REG_STATUS: rd_mux = {19'b0, fifo_count, 7'b0, fifo_empty};
            `TDC_REG_DATA:   rd_mux = fifo_empty ? 32'b0 : fifo_rdata;
            default:         rd_mux = 32'b0;   // reset register and unmapped
        endcase
    end

    always_ff @(posedge CLK40) begin
        if (RST) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK40) begin
        if (rd_hs) begin
            rdata <= rd_mux;
        end
    end

    a_bvalid_hold: assert property (@(posedge CLK40) disable iff (RST)
        bvalid && !bready |=> bvalid);

endmodule

// File: src/tdc_core.sv
// TDC core top level
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_core (
    input  logic                       CLK40,
    input  logic                       RST,
    input  tdc_pkg::sample_t           sample,
    input  logic                       arm,
    input  logic [`TDC_AXI_ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`TDC_AXI_ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    logic               enable;
    logic               arm_enable;
    logic               soft_rst;
    logic               fifo_pop;
    logic               fifo_wr;
    logic               fifo_full;
    logic               fifo_empty;
    tdc_pkg::tdc_word_t fifo_wdata;
    tdc_pkg::tdc_word_t fifo_rdata;
    tdc_pkg::fifo_cnt_t fifo_count;
    tdc_pkg::evt_cnt_t  event_cnt;
    tdc_pkg::lost_cnt_t lost_cnt;

    tdc_meas_if meas ();

    tdc_tot_counter i_tot_counter (
        .CLK40, .RST, .soft_rst, .sample,
        .meas (meas.counter)
    );

    tdc_hit_fsm i_hit_fsm (
        .CLK40, .RST, .soft_rst, .enable, .arm_enable, .arm,
        .meas (meas.fsm)
    );

    tdc_event_packer i_event_packer (
        .CLK40, .RST, .soft_rst,
        .meas       (meas.packer),
        .fifo_full, .fifo_wr, .fifo_wdata, .event_cnt, .lost_cnt
    );

    tdc_event_fifo i_event_fifo (
        .CLK40, .RST, .soft_rst,
        .wr    (fifo_wr),
        .rd    (fifo_pop),
        .wdata (fifo_wdata),
        .rdata (fifo_rdata),
        .full  (fifo_full),
        .empty (fifo_empty),
        .count (fifo_count)
    );

    tdc_axil_regs i_axil_regs (
        .CLK40, .RST,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .enable, .arm_enable, .soft_rst, .fifo_pop,
        .event_cnt, .lost_cnt, .fifo_rdata, .fifo_empty, .fifo_count
    );

endmodule

// File: dv/tb_tdc_core.sv
// TDC core testbench
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tb_tdc_core;

    localparam int TIMEOUT_CYC = 200;
    localparam int TOT_MAX     = (1 << `TDC_TOT_W) - 1;

    logic                       CLK40;
    logic                       RST     = 1'b1;
    tdc_pkg::sample_t           sample  = '0;
    logic                       arm     = 1'b0;
    logic [`TDC_AXI_ADDR_W-1:0] awaddr  = '0;
    logic                       awvalid = 1'b0;
    logic                       awready;
    logic [31:0]                wdata   = '0;
    logic [3:0]                 wstrb   = '0;
    logic                       wvalid  = 1'b0;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready  = 1'b0;
    logic [`TDC_AXI_ADDR_W-1:0] araddr  = '0;
    logic                       arvalid = 1'b0;
    logic                       arready;
    logic [31:0]                rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready  = 1'b0;

    tdc_pkg::tdc_word_t exp_q[$];  // expected FIFO words in arrival order
    tdc_pkg::evt_cnt_t  exp_evt  = '0;
    tdc_pkg::lost_cnt_t exp_lost = '0;

    tdc_core i_tdc_core (.*);

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input tdc_pkg::tdc_word_t got, input tdc_pkg::tdc_word_t exp,
                              input string what);
        if (got !== exp)
            report_failure($sformatf("error at %0t ns: %s word %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_evt(input tdc_pkg::evt_cnt_t got, input tdc_pkg::evt_cnt_t exp,
                             input string what);
        if (got !== exp)
            report_failure($sformatf("error at %0t ns: %s event count %0d, expected %0d",
                                     $time, what, got, exp));
    endtask

    task automatic check_lost(input tdc_pkg::lost_cnt_t got, input tdc_pkg::lost_cnt_t exp,
                              input string what);
        if (got !== exp)
            report_failure($sformatf("error at %0t ns: %s lost count %0d, expected %0d",
                                     $time, what, got, exp));
    endtask

    task automatic check_count(input tdc_pkg::fifo_cnt_t got, input tdc_pkg::fifo_cnt_t exp,
                               input string what);
        if (got !== exp)
            report_failure($sformatf("error at %0t ns: %s %0d, expected %0d",
                                     $time, what, got, exp));
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            report_failure($sformatf("error at %0t ns: %s read %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic axi_write(input logic [`TDC_AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        int n;
        @(posedge CLK40);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge CLK40);
        while (!(awready && wready)) begin
            n++;
            if (n > TIMEOUT_CYC) report_failure("timeout: write address or data never accepted");
            @(negedge CLK40);
        end
        @(posedge CLK40);                // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        @(negedge CLK40);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT_CYC) report_failure("timeout: no write response");
            @(negedge CLK40);
        end
        check_reg(32'(bresp), 32'h0, "write response");
        @(posedge CLK40);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [`TDC_AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        int n;
        @(posedge CLK40);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge CLK40);
        while (!arready) begin
            n++;
            if (n > TIMEOUT_CYC) report_failure("timeout: read address never accepted");
            @(negedge CLK40);
        end
        @(posedge CLK40);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(negedge CLK40);
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT_CYC) report_failure("timeout: no read data");
            @(negedge CLK40);
        end
        data = rdata;                    // stable mid-cycle
        check_reg(32'(rresp), 32'h0, "read response");
        @(posedge CLK40);
        rready <= 1'b0;
    endtask

    task automatic drive_word(input tdc_pkg::sample_t w, input logic arm_pulse);
        @(posedge CLK40);
        sample <= w;
        arm    <= arm_pulse;
    endtask

    task automatic flush();
        repeat (4) drive_word('0, 1'b0); // lets the last finish reach the FIFO
    endtask

    // three zero words lead the pulse and any arm comes with the last of them
    task automatic send_pulse(input int len, input logic do_arm);
        tdc_pkg::sample_t w;
        int               pos;
        int               left;
        drive_word('0, 1'b0);
        drive_word('0, 1'b0);
        drive_word('0, do_arm);
        pos  = $urandom_range(15, 0);    // bit 15 oldest
        left = len;
        while (left > 0) begin
            w = '0;
            while (pos >= 0 && left > 0) begin
                w[pos] = 1'b1;
                pos--;
                left--;
            end
            drive_word(w, 1'b0);
            pos = 15;
        end
    endtask

    function automatic tdc_pkg::tot_t expect_tot(input int len);
        if (len > TOT_MAX) return '0;    // overflow reads as zero
        return tdc_pkg::tot_t'(len);
    endfunction

    task automatic pulse(input int len, input logic do_arm, input logic counted);
        send_pulse(len, do_arm);
        if (counted) begin
            if (exp_q.size() < `TDC_FIFO_DEPTH)
                exp_q.push_back({`TDC_DATA_ID, exp_evt, expect_tot(len)});
            else if (exp_lost != 8'hff)
                exp_lost++;
            exp_evt++;                   // dropped words use a number too
        end
    endtask

    function automatic int random_len();
        if ($urandom_range(3, 0) == 0) return $urandom_range(300, 17);
        return $urandom_range(16, 1);
    endfunction

    task automatic wait_fifo_count(input tdc_pkg::fifo_cnt_t exp);
        logic [31:0] r;
        int          n;
        n = 0;
        axi_read(`TDC_REG_STATUS, r);
        while (r[12:8] != exp && n < TIMEOUT_CYC) begin
            n++;
            axi_read(`TDC_REG_STATUS, r);
        end
        check_count(r[12:8], exp, "FIFO occupancy");
    endtask

    task automatic check_counters(input string what);
        logic [31:0] r;
        axi_read(`TDC_REG_EVENTS, r);
        check_evt(r[15:0], exp_evt, what);
        axi_read(`TDC_REG_LOST, r);
        check_lost(r[7:0], exp_lost, what);
    endtask

    task automatic drain_and_check(input string what);
        logic [31:0]        r;
        tdc_pkg::tdc_word_t exp;
        wait_fifo_count(tdc_pkg::fifo_cnt_t'(exp_q.size()));
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            axi_read(`TDC_REG_DATA, r);
            check_word(r, exp, what);
        end
        axi_read(`TDC_REG_DATA, r);
        check_word(r, '0, "empty FIFO");
        check_counters(what);
    endtask

    task automatic soft_reset();
        axi_write(`TDC_REG_RESET, 32'h1);
        exp_q.delete();
        exp_evt  = '0;
        exp_lost = '0;
    endtask

    task automatic write_config(input logic [1:0] cfg);
        logic [31:0] r;
        axi_write(`TDC_REG_CONFIG, {30'b0, cfg});
        axi_read(`TDC_REG_CONFIG, r);
        check_reg(r, {30'b0, cfg}, "config");
    endtask

    initial begin
        logic [31:0] r;
        void'($urandom(32'hc974));
        repeat (16) @(posedge CLK40);
        RST <= 1'b0;
        flush();

        write_config(2'b01);
        write_config(2'b11);
        write_config(2'b00);
        axi_read(6'h18, r);
        check_reg(r, '0, "unmapped 0x18");
        axi_read(6'h3C, r);
        check_reg(r, '0, "unmapped 0x3c");
        axi_read(`TDC_REG_RESET, r);
        check_reg(r, '0, "reset register");

        repeat (4) pulse(random_len(), 1'b0, 1'b0); // enable clear
        flush();
        drain_and_check("disabled");

        write_config(2'b01);
        repeat (3) begin
            repeat (12) pulse(random_len(), 1'b0, 1'b1);
            flush();
            drain_and_check("random pulse");
        end

        pulse(TOT_MAX, 1'b0, 1'b1);
        pulse(TOT_MAX + 1, 1'b0, 1'b1);
        pulse(TOT_MAX + 1 + $urandom_range(300, 1), 1'b0, 1'b1);
        pulse(2, 1'b0, 1'b1);
        flush();
        drain_and_check("long pulse");

        write_config(2'b11);
        repeat (2) begin
            repeat (3) pulse(random_len(), 1'b0, 1'b0);
            pulse(random_len(), 1'b1, 1'b1);
            repeat (2) pulse(random_len(), 1'b0, 1'b0);
            flush();
            drain_and_check("armed pulse");
        end

        write_config(2'b01);
        repeat (20) pulse(random_len(), 1'b0, 1'b1);
        flush();
        drain_and_check("FIFO overflow");

        soft_reset();
        repeat (280) pulse($urandom_range(12, 1), 1'b0, 1'b1);
        flush();
        wait_fifo_count(tdc_pkg::fifo_cnt_t'(`TDC_FIFO_DEPTH));
        check_counters("lost saturation");

        soft_reset();
        wait_fifo_count('0);
        check_counters("soft reset");
        axi_read(`TDC_REG_CONFIG, r);
        check_reg(r, 32'h1, "config after soft reset");
        pulse(random_len(), 1'b0, 1'b1);
        flush();
        drain_and_check("restart");

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tdc_core.f
+incdir+src
src/tdc_pkg.sv
src/tdc_meas_if.sv
src/tdc_hit_fsm.sv
src/tdc_tot_counter.sv
src/tdc_event_packer.sv
src/tdc_event_fifo.sv
src/tdc_axil_regs.sv
src/tdc_core.sv
dv/tb_tdc_core.sv

// File: Makefile
# Verilator build and run for the TDC core testbench

VERILATOR ?= verilator
TOP       ?= tb_tdc_core
FILELIST  ?= tdc_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard src/*.svh)
SIM_BIN := $(BUILD)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
